/* hw/ubesm_pkg.sv */
`default_nettype none

package ubesm_pkg;

    // ------------------------------
    // Microword field encodings
    // ------------------------------

    typedef enum logic [2:0] {
        SQ_JMP  = 3'd0,                 // Jump to address field
        SQ_CONT = 3'd1,                 // Continue
        SQ_CJP  = 3'd2,                 // Conditional jump
        SQ_CJS  = 3'd3,                 // Conditional call
        SQ_CRTN = 3'd4,                 // Conditional return
        SQ_LDCT = 3'd5,                 // Load loop counter
        SQ_RPCT = 3'd6                  // Repeat while counter nonzero
    } seq_op_e;                         // Code 7 acts as continue

    typedef enum logic [2:0] {
        C_YES   = 3'd0,                 // Always true
        C_NORMB = 3'd1,                 // Mode bit 0
        C_RNDB  = 3'd2,                 // Mode bit 1
        C_DRG   = 3'd3,                 // Mode bit 2
        C_TR0   = 3'd4,                 // Mode bit 3
        C_TR1   = 3'd5,                 // Mode bit 4
        C_ACCZ  = 3'd6,                 // Accumulator zero
        C_ACCN  = 3'd7                  // Accumulator sign
    } cond_e;

    typedef enum logic [1:0] {
        D_CONST = 2'd0,                 // Constant ROM
        D_MODE  = 2'd1,                 // Mode register
        D_SHIFT = 2'd2,                 // Shifted accumulator
        D_ADDR  = 2'd3                  // Address field
    } dsrc_e;

    typedef enum logic [1:0] {
        F_PASS = 2'd0,                  // Y = D
        F_ADD  = 2'd1,                  // Y = acc + D
        F_AND  = 2'd2,                  // Y = acc & D
        F_XOR  = 2'd3                   // Y = acc ^ D
    } alu_func_e;

    typedef enum logic [1:0] {
        Y_NONE  = 2'd0,                 // No write
        Y_ACC   = 2'd1,                 // Accumulator
        Y_MODE  = 2'd2,                 // Mode register
        Y_SHIFT = 2'd3                  // Shift parameter
    } ydst_e;

    localparam int UWORD_FIXED_W = 13;  // All fields but the address
    localparam int DATA_W        = 64;  // Datapath word
    localparam int MODE_W        = 8;   // Mode register
    localparam int PSHIFT_W      = 7;   // Bit 6 selects left shift
    localparam int CROM_DEPTH    = 16;  // Constant ROM entries

endpackage

`default_nettype wire

/* hw/useq.sv */
`timescale 1ns/1ps
`default_nettype none

module useq #(
    parameter int UADDR_W     = 8,
    parameter int STACK_DEPTH = 4
) (
    input  wire                   clk,
    input  wire                   reset,
    input  ubesm_pkg::seq_op_e    i_sqi,        // Sequencer opcode
    input  wire   [UADDR_W-1:0]   i_a,          // Address field
    input  wire   [UADDR_W-1:0]   i_uaddr,      // Address of current word
    input  wire                   i_cond_true,  // Tested condition
    output logic  [UADDR_W-1:0]   o_next_addr   // Address to fetch
);
    import ubesm_pkg::*;

    localparam int SP_W  = $clog2(STACK_DEPTH + 1);
    localparam int IDX_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

    logic [UADDR_W-1:0] stack [STACK_DEPTH];    // Return addresses
    logic [SP_W-1:0]    sp;                     // Entries in use
    logic [UADDR_W-1:0] cnt;                    // Loop counter
    logic [UADDR_W-1:0] cont_addr;              // Incremented address
    logic [IDX_W-1:0]   top_idx;                // Topmost valid entry
    logic               stk_empty;
    logic               stk_full;
    logic               push;
    logic               pop;
    logic               ld_cnt;
    logic               dec_cnt;

    assign cont_addr = i_uaddr + 1'b1;          // Wraps at 2^UADDR_W
    assign stk_empty = (sp == '0);
    assign stk_full  = (sp == SP_W'(STACK_DEPTH));
    assign top_idx   = IDX_W'(sp - 1'b1);       // Valid only when not empty

    // ------------------------------
    // Next address select
    // ------------------------------
    always_comb begin
        o_next_addr = cont_addr;                // Default is continue
        push        = 1'b0;
        pop         = 1'b0;
        ld_cnt      = 1'b0;
        dec_cnt     = 1'b0;
        case (i_sqi)
            SQ_JMP: o_next_addr = i_a;
            SQ_CJP: if (i_cond_true) o_next_addr = i_a;
            SQ_CJS: if (i_cond_true) begin
                push        = 1'b1;             // Save return address
                o_next_addr = i_a;
            end
            SQ_CRTN: if (i_cond_true && !stk_empty) begin
                pop         = 1'b1;
                o_next_addr = stack[top_idx];
            end
            SQ_LDCT: ld_cnt = 1'b1;
            SQ_RPCT: if (cnt != '0) begin
                dec_cnt     = 1'b1;             // Loop back and count down
                o_next_addr = i_a;
            end
            default: o_next_addr = cont_addr;   // CONT and code 7
        endcase
    end

    // Stack storage
    always_ff @(posedge clk) begin
        if (push) begin
            if (stk_full)
                stack[top_idx] <= cont_addr;    // Overwrite top when full
            else
                stack[IDX_W'(sp)] <= cont_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sp  <= '0;
            cnt <= '0;
        end else begin
            if (push && !stk_full)
                sp <= sp + 1'b1;
            else if (pop)
                sp <= sp - 1'b1;
            if (ld_cnt)
                cnt <= i_a;                     // Load from address field
            else if (dec_cnt)
                cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/ucode_store.sv */
`timescale 1ns/1ps
`default_nettype none

module ucode_store #(
    parameter int UADDR_W = 8
) (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire                                         i_load,      // Write strobe
    input  wire   [UADDR_W-1:0]                         i_load_addr,
    input  wire   [ubesm_pkg::UWORD_FIXED_W+UADDR_W-1:0] i_load_word,
    input  wire   [UADDR_W-1:0]                         i_next_addr, // From sequencer
    output ubesm_pkg::seq_op_e                          o_sqi,
    output ubesm_pkg::cond_e                            o_cond,
    output logic                                        o_icc,       // Invert condition
    output ubesm_pkg::dsrc_e                            o_dsrc,
    output ubesm_pkg::alu_func_e                        o_func,
    output ubesm_pkg::ydst_e                            o_ydst,
    output logic  [UADDR_W-1:0]                         o_a,         // Address field
    output logic  [UADDR_W-1:0]                         o_uaddr      // Address of uir
);
    import ubesm_pkg::*;

    localparam int UWORD_W = UWORD_FIXED_W + UADDR_W;

    logic [UWORD_W-1:0] mem [2**UADDR_W];       // Control store
    logic [UWORD_W-1:0] uir;                    // Microinstruction register

    always_ff @(posedge clk) begin
        if (i_load)
            mem[i_load_addr] <= i_load_word;    // Load port
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            uir     <= '0;                      // Zero word is JMP 0
            o_uaddr <= '0;
        end else begin
            uir     <= mem[i_next_addr];
            o_uaddr <= i_next_addr;             // Track address with word
        end
    end

    // Field split from the MSB down
    assign o_sqi  = seq_op_e'(uir[UWORD_W-1 -: 3]);
    assign o_cond = cond_e'(uir[UWORD_W-4 -: 3]);
    assign o_icc  = uir[UWORD_W-7];
    assign o_dsrc = dsrc_e'(uir[UWORD_W-8 -: 2]);
    assign o_func = alu_func_e'(uir[UWORD_W-10 -: 2]);
    assign o_ydst = ydst_e'(uir[UADDR_W+1 -: 2]);
    assign o_a    = uir[UADDR_W-1:0];

endmodule

`default_nettype wire

/* hw/mode_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_reg (
    input  wire                              clk,
    input  wire                              reset,
    input  ubesm_pkg::cond_e                 i_cond,       // Condition select
    input  wire                              i_icc,        // Invert result
    input  ubesm_pkg::ydst_e                 i_ydst,
    input  wire   [ubesm_pkg::DATA_W-1:0]    i_y,          // Y bus
    input  wire                              i_acc_zero,
    input  wire                              i_acc_neg,
    output logic  [ubesm_pkg::MODE_W-1:0]    o_rr,         // Mode register
    output logic                             o_cond_true
);
    import ubesm_pkg::*;

    logic cond_sel;                             // Before inversion

    // ------------------------------
    // Mode register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            o_rr <= '0;
        else if (i_ydst == Y_MODE)
            o_rr <= i_y[MODE_W-1:0];            // Low byte of Y
    end

    // Condition multiplexer
    always_comb begin
        case (i_cond)
            C_YES:   cond_sel = 1'b1;
            C_NORMB: cond_sel = o_rr[0];        // Normalization block
            C_RNDB:  cond_sel = o_rr[1];        // Rounding block
            C_DRG:   cond_sel = o_rr[2];        // Dispatcher mode
            C_TR0:   cond_sel = o_rr[3];        // Trigger 0
            C_TR1:   cond_sel = o_rr[4];        // Trigger 1
            C_ACCZ:  cond_sel = i_acc_zero;
            C_ACCN:  cond_sel = i_acc_neg;
            default: cond_sel = 1'b1;
        endcase
    end

    assign o_cond_true = cond_sel ^ i_icc;

endmodule

`default_nettype wire

/* hw/alu_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_shift #(
    parameter int UADDR_W = 8
) (
    input  wire                              clk,
    input  wire                              reset,
    input  ubesm_pkg::dsrc_e                 i_dsrc,    // D bus source
    input  ubesm_pkg::alu_func_e             i_func,    // ALU operation
    input  ubesm_pkg::ydst_e                 i_ydst,    // Y bus destination
    input  wire   [UADDR_W-1:0]              i_a,       // Address field
    input  wire   [ubesm_pkg::MODE_W-1:0]    i_rr,      // Mode register
    output logic  [ubesm_pkg::DATA_W-1:0]    o_y,       // Y bus
    output logic                             o_acc_zero,
    output logic                             o_acc_neg
);
    import ubesm_pkg::*;

    logic [DATA_W-1:0]   crom [CROM_DEPTH];     // Constant ROM
    logic [DATA_W-1:0]   acc;                   // Accumulator
    logic [PSHIFT_W-1:0] pshift;                // Shift parameter
    logic [DATA_W-1:0]   shift_res;
    logic [DATA_W-1:0]   d_bus;

    initial begin
        $readmemh("hw/const_rom.hex", crom);
    end

    // ------------------------------
    // Shifter
    // ------------------------------
    always_comb begin
        if (pshift[PSHIFT_W-1])
            shift_res = acc << pshift[5:0];     // Left with zero fill
        else
            shift_res = acc >> pshift[5:0];     // Logical right shift
    end

    // D bus source select
    always_comb begin
        case (i_dsrc)
            D_CONST: d_bus = crom[i_a[3:0]];    // Low 4 address bits
            D_MODE:  d_bus = DATA_W'(i_rr);
            D_SHIFT: d_bus = shift_res;
            D_ADDR:  d_bus = DATA_W'(i_a);
            default: d_bus = '0;
        endcase
    end

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (i_func)
            F_PASS:  o_y = d_bus;
            F_ADD:   o_y = acc + d_bus;         // Carry out dropped
            F_AND:   o_y = acc & d_bus;
            F_XOR:   o_y = acc ^ d_bus;
            default: o_y = d_bus;
        endcase
    end

    // Y bus destinations
    always_ff @(posedge clk) begin
        if (reset) begin
            acc    <= '0;
            pshift <= '0;
        end else begin
            if (i_ydst == Y_ACC)
                acc <= o_y;
            if (i_ydst == Y_SHIFT)
                pshift <= o_y[PSHIFT_W-1:0];    // Direction and amount
        end
    end

    assign o_acc_zero = (acc == '0);
    assign o_acc_neg  = acc[DATA_W-1];          // Sign bit

endmodule

`default_nettype wire

/* hw/ubesm_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ubesm_core #(
    parameter int UADDR_W     = 8,              // Microaddress width
    parameter int STACK_DEPTH = 4               // Subroutine stack entries
) (
    input  wire                                          clk,
    input  wire                                          reset,
    input  wire                                          i_load,
    input  wire   [UADDR_W-1:0]                          i_load_addr,
    input  wire   [ubesm_pkg::UWORD_FIXED_W+UADDR_W-1:0] i_load_word,
    output logic  [UADDR_W-1:0]                          o_uaddr,
    output logic  [ubesm_pkg::DATA_W-1:0]                o_y
);
    import ubesm_pkg::*;

    // ------------------------------
    // Microword fields
    // ------------------------------
    seq_op_e            sqi;
    cond_e              cond;
    logic               icc;
    dsrc_e              dsrc;
    alu_func_e          func;
    ydst_e              ydst;
    logic [UADDR_W-1:0] a_fld;

    logic [UADDR_W-1:0] next_addr;              // Sequencer to store
    logic               cond_true;              // Condition to sequencer
    logic [MODE_W-1:0]  rr;                     // Mode register to datapath
    logic               acc_zero;
    logic               acc_neg;

    ucode_store #(.UADDR_W(UADDR_W)) u_store (
        .clk(clk), .reset(reset),
        .i_load(i_load), .i_load_addr(i_load_addr), .i_load_word(i_load_word),
        .i_next_addr(next_addr),
        .o_sqi(sqi), .o_cond(cond), .o_icc(icc), .o_dsrc(dsrc),
        .o_func(func), .o_ydst(ydst), .o_a(a_fld), .o_uaddr(o_uaddr)
    );

    useq #(.UADDR_W(UADDR_W), .STACK_DEPTH(STACK_DEPTH)) u_seq (
        .clk(clk), .reset(reset),
        .i_sqi(sqi), .i_a(a_fld), .i_uaddr(o_uaddr),
        .i_cond_true(cond_true), .o_next_addr(next_addr)
    );

    mode_reg u_mode (
        .clk(clk), .reset(reset),
        .i_cond(cond), .i_icc(icc), .i_ydst(ydst), .i_y(o_y),
        .i_acc_zero(acc_zero), .i_acc_neg(acc_neg),
        .o_rr(rr), .o_cond_true(cond_true)
    );

    alu_shift #(.UADDR_W(UADDR_W)) u_alu (
        .clk(clk), .reset(reset),
        .i_dsrc(dsrc), .i_func(func), .i_ydst(ydst), .i_a(a_fld), .i_rr(rr),
        .o_y(o_y), .o_acc_zero(acc_zero), .o_acc_neg(acc_neg)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 100.0            // Full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                             // First rising edge at half period
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

/* tb/tb_ubesm_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ubesm_core;
    import ubesm_pkg::*;

    localparam int UADDR_W     = 8;             // DUT defaults
    localparam int DEPTH       = 4;
    localparam int UWORD_W     = UWORD_FIXED_W + UADDR_W;
    localparam int NWORDS      = 2**UADDR_W;
    localparam int RESET_LEN   = 10;
    localparam int DIR_LEN     = 120;           // Cycles per directed program
    localparam int RAND_LEN    = 400;           // Cycles per random program
    localparam int NRAND       = 8;
    localparam int TOTAL_LEN   = RESET_LEN + (NRAND + 2) * NWORDS + 2 * DIR_LEN + NRAND * RAND_LEN;
    localparam int CYCLE_LIMIT = TOTAL_LEN + TOTAL_LEN / 10;

    logic               clk;
    logic               reset;
    logic               i_load;
    logic [UADDR_W-1:0] i_load_addr;
    logic [UWORD_W-1:0] i_load_word;
    logic [UADDR_W-1:0] o_uaddr;
    logic [DATA_W-1:0]  o_y;

    // ------------------------------
    // Reference model state
    // ------------------------------
    logic [UWORD_W-1:0]  prog [NWORDS];         // Image written to the store
    logic [DATA_W-1:0]   crom [CROM_DEPTH];
    logic [UWORD_W-1:0]  m_uir;
    logic [UADDR_W-1:0]  m_uaddr;
    logic [DATA_W-1:0]   m_acc;
    logic [MODE_W-1:0]   m_rr;
    logic [PSHIFT_W-1:0] m_pshift;
    logic [UADDR_W-1:0]  m_stack [DEPTH];
    logic [UADDR_W-1:0]  m_cnt;
    int                  m_sp;
    int                  errors = 0;
    int                  checks = 0;
    int                  cycles = 0;
    int                  visit_addr;            // Address whose visits are counted
    int                  visits;
    int                  seed_val;

    tb_clock #(.PERIOD_NS(100.0)) u_clock (.clk(clk));

    ubesm_core UUT (
        .clk(clk), .reset(reset),
        .i_load(i_load), .i_load_addr(i_load_addr), .i_load_word(i_load_word),
        .o_uaddr(o_uaddr), .o_y(o_y)
    );

    function automatic logic [UWORD_W-1:0] make_word(
        input logic [2:0] op, input logic [2:0] cnd, input logic inv,
        input logic [1:0] ds, input logic [1:0] fn, input logic [1:0] yd,
        input logic [UADDR_W-1:0] a
    );
        return {op, cnd, inv, ds, fn, yd, a};   // MSB first
    endfunction

    function automatic logic [DATA_W-1:0] model_y();
        logic [DATA_W-1:0] d;
        logic [5:0]        amt;
        amt = m_pshift[5:0];
        case (m_uir[13:12])
            D_CONST: d = crom[m_uir[3:0]];
            D_MODE:  d = {{(DATA_W-MODE_W){1'b0}}, m_rr};
            D_SHIFT: d = m_pshift[6] ? (m_acc << amt) : (m_acc >> amt);
            default: d = {{(DATA_W-UADDR_W){1'b0}}, m_uir[7:0]};
        endcase
        case (m_uir[11:10])
            F_ADD:   return m_acc + d;          // Wraps modulo 2^64
            F_AND:   return m_acc & d;
            F_XOR:   return m_acc ^ d;
            default: return d;
        endcase
    endfunction

    function automatic logic model_cond();
        logic [2:0] cnd;
        logic       r;
        cnd = m_uir[17:15];
        if (cnd == C_YES)
            r = 1'b1;
        else if (cnd <= C_TR1)
            r = m_rr[cnd - 1];                  // Mode bits 0 to 4
        else if (cnd == C_ACCZ)
            r = (m_acc == '0);
        else
            r = m_acc[DATA_W-1];
        return r ^ m_uir[14];                   // Invert bit
    endfunction

    task automatic model_reset();
        m_uir    = '0;
        m_uaddr  = '0;
        m_acc    = '0;
        m_rr     = '0;
        m_pshift = '0;
        m_cnt    = '0;
        m_sp     = 0;
    endtask

    // One clock edge of the model
    task automatic model_step();
        logic [UADDR_W-1:0] a;
        logic [UADDR_W-1:0] cont;
        logic [UADDR_W-1:0] nxt;
        logic [DATA_W-1:0]  y;
        logic               t;
        a    = m_uir[7:0];
        cont = m_uaddr + 1'b1;
        y    = model_y();                       // Uses values before the edge
        t    = model_cond();
        nxt  = cont;
        case (m_uir[20:18])
            SQ_JMP: nxt = a;
            SQ_CJP: if (t) nxt = a;
            SQ_CJS: if (t) begin
                if (m_sp == DEPTH) begin
                    m_stack[DEPTH-1] = cont;    // Top entry replaced when full
                end else begin
                    m_stack[m_sp] = cont;
                    m_sp++;
                end
                nxt = a;
            end
            SQ_CRTN: if (t && m_sp > 0) begin
                m_sp--;
                nxt = m_stack[m_sp];
            end
            SQ_LDCT: m_cnt = a;
            SQ_RPCT: if (m_cnt != '0) begin
                m_cnt = m_cnt - 1'b1;
                nxt   = a;
            end
            default: nxt = cont;                // CONT and code 7
        endcase
        case (m_uir[9:8])
            Y_ACC:   m_acc = y;
            Y_MODE:  m_rr = y[MODE_W-1:0];
            Y_SHIFT: m_pshift = y[PSHIFT_W-1:0];
            default: ;
        endcase
        m_uaddr = nxt;
        m_uir   = prog[nxt];
    endtask

    task automatic check_outputs(input logic [UADDR_W-1:0] exp_addr,
                                 input logic [DATA_W-1:0] exp_y);
        checks++;
        assert (o_uaddr === exp_addr) else begin
            errors++;
            $display("FAIL cycle %0d: o_uaddr = %h, expected %h", cycles, o_uaddr, exp_addr);
        end
        assert (o_y === exp_y) else begin
            errors++;
            $display("FAIL cycle %0d: o_y = %h, expected %h", cycles, o_y, exp_y);
        end
    endtask

    // ------------------------------
    // Program images
    // ------------------------------
    task automatic fill_self_loops();
        for (int i = 0; i < NWORDS; i++)
            prog[i] = make_word(SQ_JMP, C_YES, 1'b0, D_ADDR, F_XOR, Y_NONE, UADDR_W'(i));
    endtask

    task automatic build_seq_prog();
        int p;
        fill_self_loops();
        prog[0] = make_word(SQ_CONT, C_YES, 1'b0, D_ADDR, F_PASS, Y_MODE, 8'h15);  // Bits 0 2 4
        prog[1] = make_word(SQ_CONT, C_YES, 1'b0, D_CONST, F_PASS, Y_ACC, 8'd3);   // Acc negative
        p = 2;
        for (int c = 0; c < 8; c++) begin
            for (int inv = 0; inv < 2; inv++) begin
                prog[p]   = make_word(SQ_CJP, 3'(c), 1'(inv), D_ADDR, F_PASS, Y_NONE,
                                      UADDR_W'(p + 2));
                prog[p+1] = make_word(SQ_CONT, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'hee);
                p += 2;
            end
        end
        prog[p] = make_word(SQ_CONT, C_YES, 1'b0, D_CONST, F_XOR, Y_ACC, 8'd3);    // Acc to zero
        p++;
        for (int c = 6; c < 8; c++) begin
            for (int inv = 0; inv < 2; inv++) begin
                prog[p]   = make_word(SQ_CJP, 3'(c), 1'(inv), D_ADDR, F_PASS, Y_NONE,
                                      UADDR_W'(p + 2));
                prog[p+1] = make_word(SQ_CONT, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'hdd);
                p += 2;
            end
        end
        // Mode register round trip then AND with a constant
        prog[p]   = make_word(SQ_CONT, C_YES, 1'b0, D_MODE, F_PASS, Y_ACC, 8'h00);
        prog[p+1] = make_word(SQ_CONT, C_YES, 1'b0, D_ADDR, F_ADD, Y_MODE, 8'h2a);
        prog[p+2] = make_word(SQ_CONT, C_YES, 1'b0, D_MODE, F_XOR, Y_NONE, 8'h00);
        prog[p+3] = make_word(SQ_CONT, C_YES, 1'b0, D_CONST, F_PASS, Y_ACC, 8'd14);
        prog[p+4] = make_word(SQ_CONT, C_YES, 1'b0, D_CONST, F_AND, Y_NONE, 8'd11);
        p += 5;
        for (int k = 0; k < 6; k++) begin
            prog[p]   = make_word(SQ_CONT, C_YES, 1'b0, D_ADDR, F_PASS, Y_SHIFT,
                                  {1'b0, 1'(k), 6'($urandom)});          // Alternate direction
            prog[p+1] = make_word(SQ_CONT, C_YES, 1'b0, D_SHIFT, F_PASS, Y_NONE, 8'h00);
            prog[p+2] = make_word(SQ_CONT, C_YES, 1'b0, D_SHIFT, F_XOR, Y_ACC, 8'h00);
            p += 3;
        end
    endtask

    task automatic build_sub_prog();
        fill_self_loops();
        prog[0] = make_word(SQ_CJS, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd20);
        prog[1] = make_word(SQ_CRTN, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd0);   // Empty stack
        prog[2] = make_word(SQ_LDCT, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd3);
        prog[3] = make_word(SQ_CONT, C_YES, 1'b0, D_ADDR, F_ADD, Y_ACC, 8'd1);     // Loop body
        prog[4] = make_word(SQ_RPCT, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd3);
        prog[5] = make_word(SQ_CJS, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd30);
        prog[6] = make_word(SQ_CRTN, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd0);
        prog[7] = make_word(SQ_CJS, C_YES, 1'b1, D_ADDR, F_PASS, Y_NONE, 8'd80);   // Not taken
        prog[8] = make_word(SQ_LDCT, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd0);
        prog[9] = make_word(SQ_RPCT, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd8);   // Counter zero
        prog[20] = make_word(SQ_CRTN, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd0);
        for (int k = 3; k < 7; k++) begin                                  // Nested calls
            prog[k*10]   = make_word(SQ_CJS, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE,
                                     UADDR_W'(k*10 + 10));
            prog[k*10+1] = make_word(SQ_CRTN, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd0);
        end
        prog[70] = make_word(SQ_CRTN, C_YES, 1'b1, D_ADDR, F_PASS, Y_NONE, 8'd0);  // False
        prog[71] = make_word(SQ_CRTN, C_YES, 1'b0, D_ADDR, F_PASS, Y_NONE, 8'd0);
    endtask

    task automatic build_rand_prog();
        for (int i = 0; i < NWORDS; i++)
            prog[i] = UWORD_W'($urandom);
    endtask

    // ------------------------------
    // Load and run
    // ------------------------------
    task automatic load_program();
        for (int i = 0; i < NWORDS; i++) begin
            reset       = 1'b1;
            i_load      = 1'b1;
            i_load_addr = UADDR_W'(i);
            i_load_word = prog[i];
            @(negedge clk);
            check_outputs('0, crom[0]);          // Reset state while loading
        end
        i_load = 1'b0;
        reset  = 1'b0;
        model_reset();
    endtask

    task automatic run_program(input int ncycles);
        visits = 0;
        for (int n = 0; n < ncycles; n++) begin
            check_outputs(m_uaddr, model_y());
            if (n == 1) begin
                assert (o_uaddr === '0) else begin
                    errors++;
                    $display("FAIL first o_uaddr after reset = %h, expected %h", o_uaddr, 8'h00);
                end
            end
            if (n > 0 && o_uaddr == visit_addr)
                visits++;
            model_step();
            @(negedge clk);
        end
    endtask

    initial begin
        seed_val    = $urandom(32'had8338df);   // Seed once for the whole run
        reset       = 1'b1;
        i_load      = 1'b0;
        i_load_addr = '0;
        i_load_word = '0;
        visit_addr  = -1;
        $readmemh("hw/const_rom.hex", crom);
        repeat (RESET_LEN) begin
            @(negedge clk);
            check_outputs('0, crom[0]);
        end
        build_seq_prog();
        load_program();
        run_program(DIR_LEN);
        build_sub_prog();
        visit_addr = 3;
        load_program();
        run_program(DIR_LEN);
        assert (visits == 4) else begin
            errors++;
            $display("Loop body ran %0d times instead of 4", visits);
        end
        visit_addr = -1;
        for (int p = 0; p < NRAND; p++) begin
            build_rand_prog();
            load_program();
            run_program(RAND_LEN);
        end
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog on total cycle count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Summary: %0d errors in %0d checks", errors, checks);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hw/const_rom.hex */
// Constant ROM, one 64-bit hex word per line
// Line order is entry 0 up to entry 15
0123456789abcdef
0000000000000001
ffffffffffffffff
8000000000000000
00000000000000ff
5555aaaa3333cccc
0000000000000000
7fffffffffffffff
9e3779b97f4a7c15
00000000ffffffff
ffffffff00000000
0f0f0f0f0f0f0f0f
f0f0f0f0f0f0f0f0
0000000000000080
243f6a8885a308d3
c90fdaa22168c234

/* flist.f */
hw/ubesm_pkg.sv
hw/useq.sv
hw/ucode_store.sv
hw/mode_reg.sv
hw/alu_shift.sv
hw/ubesm_core.sv
tb/tb_clock.sv
tb/tb_ubesm_core.sv

/* Bender.yml */
package:
  name: ubesm_core

sources:
  - hw/ubesm_pkg.sv
  - hw/useq.sv
  - hw/ucode_store.sv
  - hw/mode_reg.sv
  - hw/alu_shift.sv
  - hw/ubesm_core.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/tb_ubesm_core.sv
